/* aipBusPkg.sv */
package aipBusPkg;

  localparam int DATA_WIDTH   = 32;
  localparam int CONFIG_WIDTH = 5;

  // Host bus configuration codes
  typedef enum logic [CONFIG_WIDTH-1:0] {
    MEM_IN_DATA  = 5'd0,
    MEM_IN_ADDR  = 5'd1,
    MEM_OUT_DATA = 5'd2,
    MEM_OUT_ADDR = 5'd3,
    CONF_DATA    = 5'd4,
    CONF_ADDR    = 5'd5,
    STATUS       = 5'd30,
    ID           = 5'd31
  } aipOpcode_e;

  // Readback source of dataOutAIP
  typedef enum logic [1:0] {
    READ_MEM_OUT = 2'd0,
    READ_STATUS  = 2'd1,
    READ_ID      = 2'd2,
    READ_ZERO    = 2'd3   // Unmapped codes read as zero
  } aipReadSrc_e;

  localparam logic [DATA_WIDTH-1:0] IP_ID = 32'h00001001;

endpackage

/* aipCorePkg.sv */
package aipCorePkg;

  // Memory geometry, 64 words each
  localparam int MEM_IN_ADDR_WIDTH  = 6;
  localparam int MEM_OUT_ADDR_WIDTH = 6;

  // Config register bank
  localparam int CONF_REG_COUNT  = 1;
  localparam int CONF_ADDR_WIDTH = 1;

  // Status word layout
  localparam int STATUS_WIDTH    = 8;
  localparam int STATUS_BUSY_LSB = 0;
  localparam int STATUS_FLAG_LSB = 8;
  localparam int STATUS_MASK_LSB = 16;

endpackage

/* aipRam.sv */
`timescale 1ns/1ps

module aipRam #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  clk,
  input  logic                  wrEn_i,
  input  logic [ADDR_WIDTH-1:0] wrAddr_i,
  input  logic [DATA_WIDTH-1:0] wrData_i,
  input  logic [ADDR_WIDTH-1:0] rdAddr_i,
  output logic [DATA_WIDTH-1:0] rdData_o
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  assign rdData_o = mem[rdAddr_i];  // Async read

  // Pointer from control must be settled when a write is taken
  wrAddrKnown: assert property (
    @(posedge clk) wrEn_i |-> !$isunknown(wrAddr_i)
  ) else $error("aipRam write with unknown address");

endmodule

/* aipCtrl.sv */
`timescale 1ns/1ps

module aipCtrl
  import aipBusPkg::*, aipCorePkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          en_i,
  input  logic                          writeAIP_i,
  input  logic                          readAIP_i,
  input  aipOpcode_e                    configAIP_i,
  input  logic [DATA_WIDTH-1:0]         memAddr_i,
  output logic                          wrEnMemIn_o,
  output logic [MEM_IN_ADDR_WIDTH-1:0]  wrAddrMemIn_o,
  output logic [MEM_OUT_ADDR_WIDTH-1:0] rdAddrMemOut_o,
  output logic                          wrEnConf_o,
  output logic [CONF_ADDR_WIDTH-1:0]    wrAddrConf_o,
  output logic                          setStatus_o,
  output aipReadSrc_e                   readSrc_o
);

  logic [MEM_IN_ADDR_WIDTH-1:0]  memInPtr;
  logic [MEM_OUT_ADDR_WIDTH-1:0] memOutPtr;
  logic [CONF_ADDR_WIDTH-1:0]    confPtr;

  logic loadMemIn;
  logic loadMemOut;
  logic loadConf;
  logic readMemOut;

  // Data writes, one target per strobe
  assign wrEnMemIn_o = writeAIP_i && (configAIP_i == MEM_IN_DATA);
  assign wrEnConf_o  = writeAIP_i && (configAIP_i == CONF_DATA);
  assign setStatus_o = writeAIP_i && (configAIP_i == STATUS);

  // Pointer loads
  assign loadMemIn  = writeAIP_i && (configAIP_i == MEM_IN_ADDR);
  assign loadMemOut = writeAIP_i && (configAIP_i == MEM_OUT_ADDR);
  assign loadConf   = writeAIP_i && (configAIP_i == CONF_ADDR);

  assign readMemOut = readAIP_i && (configAIP_i == MEM_OUT_DATA);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memInPtr  <= '0;
      memOutPtr <= '0;
      confPtr   <= '0;
    end else if (en_i) begin  // Pointers frozen while disabled
      if (loadMemIn) begin
        memInPtr <= memAddr_i[MEM_IN_ADDR_WIDTH-1:0];
      end else if (wrEnMemIn_o) begin
        memInPtr <= memInPtr + 1'b1;  // Wraps at memory depth
      end

      if (loadMemOut) begin
        memOutPtr <= memAddr_i[MEM_OUT_ADDR_WIDTH-1:0];
      end else if (readMemOut) begin
        memOutPtr <= memOutPtr + 1'b1;
      end

      if (loadConf) begin
        confPtr <= memAddr_i[CONF_ADDR_WIDTH-1:0];
      end else if (wrEnConf_o) begin
        // Bank size need not be a power of two
        if (confPtr == CONF_ADDR_WIDTH'(CONF_REG_COUNT - 1)) begin
          confPtr <= '0;
        end else begin
          confPtr <= confPtr + 1'b1;
        end
      end
    end
  end

  assign wrAddrMemIn_o  = memInPtr;
  assign rdAddrMemOut_o = memOutPtr;
  assign wrAddrConf_o   = confPtr;

  always_comb begin
    case (configAIP_i)
      MEM_OUT_DATA: readSrc_o = READ_MEM_OUT;
      STATUS:       readSrc_o = READ_STATUS;
      ID:           readSrc_o = READ_ID;
      default:      readSrc_o = READ_ZERO;
    endcase
  end

  // Memory, config and status writes never overlap
  oneWriteTarget: assert property (
    @(posedge clk) disable iff (!rst)
    $onehot0({wrEnMemIn_o, wrEnConf_o, setStatus_o})
  ) else $error("aipCtrl more than one write target enabled");

endmodule

/* aipConfReg.sv */
`timescale 1ns/1ps

module aipConfReg
  import aipBusPkg::*, aipCorePkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 wrEn_i,
  input  logic [CONF_ADDR_WIDTH-1:0]           wrAddr_i,
  input  logic [DATA_WIDTH-1:0]                wrData_i,
  output logic [CONF_REG_COUNT*DATA_WIDTH-1:0] confData_o
);

  logic [DATA_WIDTH-1:0] confRegs [CONF_REG_COUNT];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < CONF_REG_COUNT; i++) begin
        confRegs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < CONF_REG_COUNT; i++) begin
        // Compare per entry so the address never indexes past the bank
        if (wrEn_i && (wrAddr_i == CONF_ADDR_WIDTH'(i))) begin
          confRegs[i] <= wrData_i;
        end
      end
    end
  end

  // Register 0 in the low word
  always_comb begin
    for (int i = 0; i < CONF_REG_COUNT; i++) begin
      confData_o[i*DATA_WIDTH +: DATA_WIDTH] = confRegs[i];
    end
  end

endmodule

/* aipStatus.sv */
`timescale 1ns/1ps

module aipStatus
  import aipBusPkg::*, aipCorePkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    setStatus_i,
  input  logic [DATA_WIDTH-1:0]   dataIn_i,
  input  logic [STATUS_WIDTH-1:0] busy_i,
  input  logic [STATUS_WIDTH-1:0] done_i,
  output logic [DATA_WIDTH-1:0]   statusWord_o,
  output logic                    intReq_o
);

  logic [STATUS_WIDTH-1:0] flags;
  logic [STATUS_WIDTH-1:0] mask;
  logic [STATUS_WIDTH-1:0] clrFlags;

  // Host clears flags by writing ones
  assign clrFlags = setStatus_i ? dataIn_i[STATUS_FLAG_LSB +: STATUS_WIDTH] : '0;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      flags    <= '0;
      mask     <= '0;
      intReq_o <= 1'b0;
    end else begin
      flags    <= (flags & ~clrFlags) | done_i;  // Set beats clear
      intReq_o <= |(flags & mask);
      if (setStatus_i) begin
        mask <= dataIn_i[STATUS_MASK_LSB +: STATUS_WIDTH];
      end
    end
  end

  always_comb begin
    statusWord_o = '0;
    statusWord_o[STATUS_BUSY_LSB +: STATUS_WIDTH] = busy_i;
    statusWord_o[STATUS_FLAG_LSB +: STATUS_WIDTH] = flags;
    statusWord_o[STATUS_MASK_LSB +: STATUS_WIDTH] = mask;
  end

  // Request is one cycle behind the mask, so an empty mask keeps it quiet
  noIntWithoutMask: assert property (
    @(posedge clk) disable iff (!rst)
    ($past(mask) == '0) |-> !intReq_o
  ) else $error("aipStatus interrupt raised with mask cleared");

endmodule

/* aipTop.sv */
`timescale 1ns/1ps

module aipTop
  import aipBusPkg::*, aipCorePkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 en_i,
  // Host bus
  input  logic [CONFIG_WIDTH-1:0]              configAIP_i,
  input  logic [DATA_WIDTH-1:0]                dataInAIP_i,
  input  logic                                 writeAIP_i,
  input  logic                                 readAIP_i,
  input  logic                                 startAIP_i,
  output logic [DATA_WIDTH-1:0]                dataOutAIP_o,
  output logic                                 intAIP_o,
  // Core side
  input  logic [MEM_IN_ADDR_WIDTH-1:0]         rdAddrMemIn_i,
  output logic [DATA_WIDTH-1:0]                rdDataMemIn_o,
  input  logic [DATA_WIDTH-1:0]                wrDataMemOut_i,
  input  logic [MEM_OUT_ADDR_WIDTH-1:0]        wrAddrMemOut_i,
  input  logic                                 wrEnMemOut_i,
  output logic [CONF_REG_COUNT*DATA_WIDTH-1:0] rdDataConfigReg_o,
  input  logic                                 statusBusy_i,
  input  logic                                 intDone_i,
  output logic                                 startIPcore_o
);

  logic                          wrEnMemIn;
  logic [MEM_IN_ADDR_WIDTH-1:0]  wrAddrMemIn;
  logic [MEM_OUT_ADDR_WIDTH-1:0] rdAddrMemOut;
  logic [DATA_WIDTH-1:0]         rdDataMemOut;
  logic                          wrEnConf;
  logic [CONF_ADDR_WIDTH-1:0]    wrAddrConf;
  logic                          setStatus;
  logic [DATA_WIDTH-1:0]         statusWord;
  aipReadSrc_e                   readSrc;

  assign startIPcore_o = startAIP_i;

  aipRam #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(MEM_IN_ADDR_WIDTH)) memIn (
    .clk      (clk),
    .wrEn_i   (wrEnMemIn),
    .wrAddr_i (wrAddrMemIn),
    .wrData_i (dataInAIP_i),
    .rdAddr_i (rdAddrMemIn_i),
    .rdData_o (rdDataMemIn_o)
  );

  aipRam #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(MEM_OUT_ADDR_WIDTH)) memOut (
    .clk      (clk),
    .wrEn_i   (wrEnMemOut_i),
    .wrAddr_i (wrAddrMemOut_i),
    .wrData_i (wrDataMemOut_i),
    .rdAddr_i (rdAddrMemOut),
    .rdData_o (rdDataMemOut)
  );

  aipCtrl ctrl (
    .clk            (clk),
    .rst            (rst),
    .en_i           (en_i),
    .writeAIP_i     (writeAIP_i),
    .readAIP_i      (readAIP_i),
    .configAIP_i    (aipOpcode_e'(configAIP_i)),
    .memAddr_i      (dataInAIP_i),
    .wrEnMemIn_o    (wrEnMemIn),
    .wrAddrMemIn_o  (wrAddrMemIn),
    .rdAddrMemOut_o (rdAddrMemOut),
    .wrEnConf_o     (wrEnConf),
    .wrAddrConf_o   (wrAddrConf),
    .setStatus_o    (setStatus),
    .readSrc_o      (readSrc)
  );

  aipConfReg confReg (
    .clk        (clk),
    .rst        (rst),
    .wrEn_i     (wrEnConf),
    .wrAddr_i   (wrAddrConf),
    .wrData_i   (dataInAIP_i),
    .confData_o (rdDataConfigReg_o)
  );

  // Core drives bit 0 of busy and done only
  aipStatus status (
    .clk          (clk),
    .rst          (rst),
    .setStatus_i  (setStatus),
    .dataIn_i     (dataInAIP_i),
    .busy_i       ({{(STATUS_WIDTH-1){1'b0}}, statusBusy_i}),
    .done_i       ({{(STATUS_WIDTH-1){1'b0}}, intDone_i}),
    .statusWord_o (statusWord),
    .intReq_o     (intAIP_o)
  );

  always_comb begin
    case (readSrc)
      READ_MEM_OUT: dataOutAIP_o = rdDataMemOut;
      READ_STATUS:  dataOutAIP_o = statusWord;
      READ_ID:      dataOutAIP_o = IP_ID;
      default:      dataOutAIP_o = '0;
    endcase
  end

endmodule

/* tbAip.sv */
`timescale 1ns/1ps

module tbAip
  import aipBusPkg::*;
();

  typedef enum {
    HOST_WR,
    HOST_RD,
    CORE_WR,
    CORE_RD,
    CONF_CHK,
    DONE_PULSE,
    INT_CHK,
    EN_SET,
    BUSY_SET,
    START_CHK
  } rowKind_e;

  // One table row, applied in one clock cycle
  typedef struct {
    rowKind_e          kind;
    logic [4:0]        code;
    logic [5:0]        addr;   // Core side address
    logic [31:0]       data;   // Host data, host pointer value or core write data
    logic [31:0]       expVal;
  } stimRow_t;

  localparam logic [31:0] EXP_ID = 32'h00001001;

  logic        clk = 1'b0;
  logic        rst;
  logic        en;
  logic [4:0]  configAIP;
  logic [31:0] dataInAIP;
  logic        writeAIP;
  logic        readAIP;
  logic        startAIP;
  logic [31:0] dataOutAIP;
  logic        intAIP;
  logic [5:0]  rdAddrMemIn;
  logic [31:0] rdDataMemIn;
  logic [31:0] wrDataMemOut;
  logic [5:0]  wrAddrMemOut;
  logic        wrEnMemOut;
  logic [31:0] rdDataConfigReg;
  logic        statusBusy;
  logic        intDone;
  logic        startIPcore;

  stimRow_t    rows[$];
  logic [31:0] lcgState = 32'h59ef0310;
  logic        tableReady = 1'b0;

  always #10 clk = ~clk;

  aipTop dut0 (
    .clk               (clk),
    .rst               (rst),
    .en_i              (en),
    .configAIP_i       (configAIP),
    .dataInAIP_i       (dataInAIP),
    .writeAIP_i        (writeAIP),
    .readAIP_i         (readAIP),
    .startAIP_i        (startAIP),
    .dataOutAIP_o      (dataOutAIP),
    .intAIP_o          (intAIP),
    .rdAddrMemIn_i     (rdAddrMemIn),
    .rdDataMemIn_o     (rdDataMemIn),
    .wrDataMemOut_i    (wrDataMemOut),
    .wrAddrMemOut_i    (wrAddrMemOut),
    .wrEnMemOut_i      (wrEnMemOut),
    .rdDataConfigReg_o (rdDataConfigReg),
    .statusBusy_i      (statusBusy),
    .intDone_i         (intDone),
    .startIPcore_o     (startIPcore)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Busy in the low byte, flags above it, mask above the flags
  function automatic logic [31:0] packStatus(input logic [7:0] busy, input logic [7:0] flag,
                                             input logic [7:0] mask);
    return {8'h00, mask, flag, busy};
  endfunction

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("Some tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic addRow(input rowKind_e kind, input logic [4:0] code, input logic [5:0] addr,
                        input logic [31:0] data, input logic [31:0] expVal);
    stimRow_t r;
    r.kind   = kind;
    r.code   = code;
    r.addr   = addr;
    r.data   = data;
    r.expVal = expVal;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    logic [31:0] inWords[5];
    logic [31:0] outModel[64];
    logic [5:0]  outAddrs[4];
    logic [31:0] confWords[2];
    logic [31:0] enWords[3];
    logic [31:0] word;

    outAddrs = '{6'd0, 6'd63, 6'd1, 6'd62};

    // State right after reset, busy held high by the core
    addRow(HOST_RD, ID, 0, 0, EXP_ID);
    addRow(HOST_RD, STATUS, 0, 0, packStatus(8'h01, 8'h00, 8'h00));
    addRow(INT_CHK, 0, 0, 0, 0);
    addRow(HOST_RD, CONF_ADDR, 0, 0, 0);  // Unmapped readback

    // Input memory, pointer wraps at 64
    addRow(HOST_WR, MEM_IN_ADDR, 0, 62, 0);
    for (int i = 0; i < 5; i++) begin
      inWords[i] = nextRand();
      addRow(HOST_WR, MEM_IN_DATA, 0, inWords[i], 0);
    end
    for (int i = 0; i < 5; i++) begin
      addRow(CORE_RD, 0, 6'((62 + i) % 64), 0, inWords[i]);
    end

    // Output memory filled out of order, drained in address order
    for (int i = 0; i < 4; i++) begin
      word = nextRand();
      outModel[outAddrs[i]] = word;
      addRow(CORE_WR, 0, outAddrs[i], word, 0);
    end
    addRow(HOST_WR, MEM_OUT_ADDR, 0, 62, 0);
    for (int j = 0; j < 4; j++) begin
      addRow(HOST_RD, MEM_OUT_DATA, 0, 0, outModel[6'((62 + j) % 64)]);
    end

    // Single config register, second write lands on it again
    confWords[0] = nextRand();
    confWords[1] = nextRand();
    addRow(HOST_WR, CONF_ADDR, 0, 0, 0);
    addRow(HOST_WR, CONF_DATA, 0, confWords[0], 0);
    addRow(CONF_CHK, 0, 0, 0, confWords[0]);
    addRow(HOST_WR, CONF_DATA, 0, confWords[1], 0);
    addRow(CONF_CHK, 0, 0, 0, confWords[1]);

    // Interrupt flag, mask and clear
    addRow(DONE_PULSE, 0, 0, 0, 0);
    addRow(HOST_RD, STATUS, 0, 0, packStatus(8'h01, 8'h01, 8'h00));
    addRow(INT_CHK, 0, 0, 0, 0);
    addRow(HOST_WR, STATUS, 0, packStatus(8'h00, 8'h00, 8'h01), 0);
    addRow(INT_CHK, 0, 0, 0, 0);  // Mask just landed
    addRow(INT_CHK, 0, 0, 0, 1);
    addRow(HOST_RD, STATUS, 0, 0, packStatus(8'h01, 8'h01, 8'h01));
    addRow(HOST_WR, STATUS, 0, packStatus(8'h00, 8'h01, 8'h01), 0);
    addRow(INT_CHK, 0, 0, 0, 1);
    addRow(INT_CHK, 0, 0, 0, 0);
    addRow(HOST_RD, STATUS, 0, 0, packStatus(8'h01, 8'h00, 8'h01));

    // Busy bit follows the core
    addRow(BUSY_SET, 0, 0, 0, 0);
    addRow(HOST_RD, STATUS, 0, 0, packStatus(8'h00, 8'h00, 8'h01));

    // Pointers frozen while en is low
    for (int i = 0; i < 3; i++) begin
      enWords[i] = nextRand();
    end
    addRow(HOST_WR, MEM_IN_ADDR, 0, 20, 0);
    addRow(EN_SET, 0, 0, 0, 0);
    addRow(HOST_WR, MEM_IN_DATA, 0, enWords[0], 0);
    addRow(HOST_WR, MEM_IN_DATA, 0, enWords[1], 0);
    addRow(CORE_RD, 0, 20, 0, enWords[1]);
    addRow(HOST_WR, MEM_IN_ADDR, 0, 40, 0);  // Ignored, pointer stays at 20
    addRow(EN_SET, 0, 0, 1, 0);
    addRow(HOST_WR, MEM_IN_DATA, 0, enWords[2], 0);
    addRow(CORE_RD, 0, 20, 0, enWords[2]);

    // Start goes straight through
    addRow(START_CHK, 0, 0, 1, 1);
    addRow(START_CHK, 0, 0, 0, 0);
  endtask

  task automatic applyRow(input stimRow_t r);
    writeAIP   = 1'b0;
    readAIP    = 1'b0;
    intDone    = 1'b0;
    wrEnMemOut = 1'b0;
    startAIP   = 1'b0;
    configAIP  = r.code;
    dataInAIP  = r.data;
    case (r.kind)
      HOST_WR:    writeAIP = 1'b1;
      HOST_RD:    readAIP = 1'b1;  // Advances the read pointer on MEM_OUT_DATA
      CORE_WR: begin
        wrEnMemOut   = 1'b1;
        wrAddrMemOut = r.addr;
        wrDataMemOut = r.data;
      end
      CORE_RD:    rdAddrMemIn = r.addr;
      DONE_PULSE: intDone = 1'b1;
      EN_SET:     en = r.data[0];
      BUSY_SET:   statusBusy = r.data[0];
      START_CHK:  startAIP = r.data[0];
      default: ;
    endcase
  endtask

  task automatic checkRow(input stimRow_t r, input int idx);
    string msg;
    msg = $sformatf("row %0d %s", idx, r.kind.name());
    case (r.kind)
      HOST_RD:   checkEq(dataOutAIP, r.expVal, msg);
      CORE_RD:   checkEq(rdDataMemIn, r.expVal, msg);
      CONF_CHK:  checkEq(rdDataConfigReg, r.expVal, msg);
      INT_CHK:   checkEq({31'b0, intAIP}, r.expVal, msg);
      START_CHK: checkEq({31'b0, startIPcore}, r.expVal, msg);
      default: ;
    endcase
  endtask

  initial begin
    rst          = 1'b0;
    en           = 1'b1;
    configAIP    = '0;
    dataInAIP    = '0;
    writeAIP     = 1'b0;
    readAIP      = 1'b0;
    startAIP     = 1'b0;
    rdAddrMemIn  = '0;
    wrDataMemOut = '0;
    wrAddrMemOut = '0;
    wrEnMemOut   = 1'b0;
    statusBusy   = 1'b1;
    intDone      = 1'b0;

    buildTable();
    tableReady = 1'b1;

    repeat (5) @(posedge clk);
    #2 rst = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #2;
      applyRow(rows[i]);
      @(negedge clk);  // Outputs settled mid cycle
      checkRow(rows[i], i);
    end

    $display("All tests passed");
    $finish;
  end

  initial begin
    wait (tableReady);
    repeat (rows.size() * 3 + 100) @(posedge clk);
    $display("Timeout: the stimulus table did not finish in the expected time");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* build.f */
aipBusPkg.sv
aipCorePkg.sv
aipRam.sv
aipCtrl.sv
aipConfReg.sv
aipStatus.sv
aipTop.sv
tbAip.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbAip -f build.f -o simAip

# A failing run stops with a nonzero status, the search below decides
output=$(./obj_dir/simAip 2>&1) || true
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
  exit 0
else
  exit 1
fi
